//--- logic/capture_pkg.sv
package capture_pkg;

    //////////////////////////////////////////////////
    // Sizes

    localparam int N_CHAN  = 4;            // Capture channels
    localparam int DEPTH   = 64;           // Entries per channel memory
    localparam int ENTRY_W = $clog2(DEPTH);
    localparam int CHAN_W  = $clog2(N_CHAN);
    localparam int IN_W    = 36;           // Raw input word
    localparam int WORD_W  = 32;           // Stored and returned word

    //////////////////////////////////////////////////
    // Bus address map

    localparam int ADDR_W     = 10;
    localparam int STATUS_BIT = 8;         // Set for a pointer read
    localparam int CHAN_LSB   = 6;         // Channel field is [7:6], entry field is [5:0]

    //////////////////////////////////////////////////
    // Types

    typedef logic [IN_W-1:0]    in_word_t;
    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [ENTRY_W-1:0] entry_t;
    typedef logic [CHAN_W-1:0]  chan_t;
    typedef logic [ADDR_W-1:0]  addr_t;

    // Readback controller states
    typedef enum logic {
        IDLE,
        WAIT
    } fsm_state_t;

endpackage

//--- logic/readback_if.sv
`timescale 1ns/1ps

interface readback_if;

    // Request from the controller, one cycle strobe
    logic                 req;
    capture_pkg::chan_t   chan;
    capture_pkg::entry_t  entry;
    logic                 status;    // Pointer read instead of memory read

    // Answer from the channel bank, two cycles after req
    capture_pkg::word_t   word;
    logic                 valid;

    modport ctrl (
        output req,
        output chan,
        output entry,
        output status,
        input  word,
        input  valid
    );

    modport bank (
        input  req,
        input  chan,
        input  entry,
        input  status,
        output word,
        output valid
    );

endinterface

//--- logic/write_pointer.sv
`timescale 1ns/1ps

module write_pointer (
    input  logic                  clk,
    input  logic                  rst,
    input  capture_pkg::in_word_t din,
    output logic                  we,
    output capture_pkg::entry_t   wr_entry
);

    capture_pkg::entry_t ptr;

    // Any set bit counts, upper bits included
    assign we = |din;

    // Wraps after DEPTH entries, oldest data gets overwritten
    always_ff @(posedge clk) begin
        if (rst) begin
            ptr <= '0;
        end else if (we) begin
            ptr <= ptr + 1'b1;
        end
    end

    assign wr_entry = ptr;    // Also the status count

endmodule

//--- logic/capture_memory.sv
`timescale 1ns/1ps

module capture_memory (
    input  logic                clk,
    input  logic                we,
    input  capture_pkg::entry_t wr_entry,
    input  capture_pkg::word_t  wr_word,
    input  capture_pkg::entry_t rd_entry,
    output capture_pkg::word_t  rd_word
);

    capture_pkg::word_t mem [capture_pkg::DEPTH];

    //////////////////////////////////////////////////
    // Write port

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_entry] <= wr_word;
        end
    end

    //////////////////////////////////////////////////
    // Read port

    // Reads every cycle; same-edge write to the same entry returns the old word
    always_ff @(posedge clk) begin
        rd_word <= mem[rd_entry];
    end

endmodule

//--- logic/capture_bank.sv
`timescale 1ns/1ps

module capture_bank (
    input  logic                  clk,
    input  logic                  rst,
    input  capture_pkg::in_word_t chan_data [capture_pkg::N_CHAN],
    readback_if.bank              rb
);

    logic                we       [capture_pkg::N_CHAN];
    capture_pkg::entry_t wr_entry [capture_pkg::N_CHAN];
    capture_pkg::word_t  mem_word [capture_pkg::N_CHAN];

    // Stage one registers
    logic                s1_valid;
    capture_pkg::chan_t  s1_chan;
    logic                s1_status;
    capture_pkg::entry_t ptr_snap [capture_pkg::N_CHAN];

    //////////////////////////////////////////////////
    // Channels

    for (genvar i = 0; i < capture_pkg::N_CHAN; i++) begin : g_chan
        write_pointer ptr_i (
            .clk      (clk),
            .rst      (rst),
            .din      (chan_data[i]),
            .we       (we[i]),
            .wr_entry (wr_entry[i])
        );

        capture_memory mem_i (
            .clk      (clk),
            .we       (we[i]),
            .wr_entry (wr_entry[i]),
            .wr_word  (chan_data[i][capture_pkg::WORD_W-1:0]),    // Low bits only
            .rd_entry (rb.entry),
            .rd_word  (mem_word[i])
        );
    end

    //////////////////////////////////////////////////
    // Stage one, same edge as the memory read

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= rb.req;
        end
    end

    always_ff @(posedge clk) begin
        s1_chan   <= rb.chan;
        s1_status <= rb.status;
        ptr_snap  <= wr_entry;    // Pointers before this edge's capture
    end

    //////////////////////////////////////////////////
    // Stage two, channel and status select

    always_ff @(posedge clk) begin
        if (rst) begin
            rb.valid <= 1'b0;
        end else begin
            rb.valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_status) begin
            rb.word <= {{(capture_pkg::WORD_W - capture_pkg::ENTRY_W){1'b0}},
                        ptr_snap[s1_chan]};
        end else begin
            rb.word <= mem_word[s1_chan];
        end
    end

endmodule

//--- logic/readback_fsm.sv
`timescale 1ns/1ps

module readback_fsm (
    input  logic                clk,
    input  logic                rst,
    input  logic                io_sel,
    input  logic                io_rd_en,
    input  capture_pkg::addr_t  io_addr,
    output capture_pkg::word_t  io_rd_data,
    output logic                io_rd_ack,
    readback_if.ctrl            rb
);

    capture_pkg::fsm_state_t state;
    logic                    accept;

    // Requests during WAIT are dropped
    assign accept = (state == capture_pkg::IDLE) && io_sel && io_rd_en;

    //////////////////////////////////////////////////
    // State and strobes

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= capture_pkg::IDLE;
            rb.req    <= 1'b0;
            io_rd_ack <= 1'b0;
        end else begin
            rb.req    <= 1'b0;    // One cycle pulses
            io_rd_ack <= 1'b0;
            case (state)
                capture_pkg::IDLE: begin
                    if (accept) begin
                        rb.req <= 1'b1;
                        state  <= capture_pkg::WAIT;
                    end
                end
                capture_pkg::WAIT: begin
                    if (rb.valid) begin
                        io_rd_ack <= 1'b1;
                        state     <= capture_pkg::IDLE;
                    end
                end
                default: begin
                    state <= capture_pkg::IDLE;
                end
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Address split

    always_ff @(posedge clk) begin
        if (accept) begin
            rb.chan   <= io_addr[capture_pkg::CHAN_LSB +: capture_pkg::CHAN_W];
            rb.entry  <= io_addr[capture_pkg::ENTRY_W-1:0];
            rb.status <= io_addr[capture_pkg::STATUS_BIT];
        end
    end

    //////////////////////////////////////////////////
    // Read data, held until the next ack

    always_ff @(posedge clk) begin
        if (rst) begin
            io_rd_data <= '0;
        end else if (state == capture_pkg::WAIT && rb.valid) begin
            io_rd_data <= rb.word;
        end
    end

endmodule

//--- logic/capture_top.sv
`timescale 1ns/1ps

module capture_top (
    input  logic                  clk,
    input  logic                  rst,
    input  capture_pkg::in_word_t chan_data [capture_pkg::N_CHAN],
    input  logic                  io_sel,
    input  logic                  io_rd_en,
    input  capture_pkg::addr_t    io_addr,
    output capture_pkg::word_t    io_rd_data,
    output logic                  io_rd_ack
);

    // Controller to bank request path
    readback_if rb_if ();

    //////////////////////////////////////////////////
    // Capture channels

    capture_bank bank_i (
        .clk       (clk),
        .rst       (rst),
        .chan_data (chan_data),
        .rb        (rb_if.bank)
    );

    //////////////////////////////////////////////////
    // Bus side

    readback_fsm fsm_i (
        .clk        (clk),
        .rst        (rst),
        .io_sel     (io_sel),
        .io_rd_en   (io_rd_en),
        .io_addr    (io_addr),
        .io_rd_data (io_rd_data),
        .io_rd_ack  (io_rd_ack),
        .rb         (rb_if.ctrl)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;    // 8 ns period

endmodule

//--- tests/capture_assertions.sv
`timescale 1ns/1ps

module capture_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    io_sel,
    input logic                    io_rd_en,
    input logic                    io_rd_ack,
    input capture_pkg::fsm_state_t state
);

    logic accept;

    // Same acceptance rule as the bus controller
    assign accept = (state == capture_pkg::IDLE) && io_sel && io_rd_en;

    //////////////////////////////////////////////////
    // Ack protocol

    ack_one_cycle: assert property (
        @(posedge clk) disable iff (rst) io_rd_ack |=> !io_rd_ack
    ) else $error("io_rd_ack high for two cycles in a row");

    ack_after_accept: assert property (
        @(posedge clk) disable iff (rst) accept |-> ##4 io_rd_ack
    ) else $error("io_rd_ack missing 4 cycles after an accepted request");

    ack_needs_request: assert property (
        @(posedge clk) disable iff (rst) io_rd_ack |-> $past(accept, 4)
    ) else $error("io_rd_ack without an accepted request 4 cycles before");

    // Ack stays low in the cycle after every reset edge
    ack_low_in_reset: assert property (
        @(posedge clk) $past(rst) |-> !io_rd_ack
    ) else $error("io_rd_ack high during reset");

endmodule

bind capture_top capture_assertions asrt_i (
    .clk       (clk),
    .rst       (rst),
    .io_sel    (io_sel),
    .io_rd_en  (io_rd_en),
    .io_rd_ack (io_rd_ack),
    .state     (fsm_i.state)
);

//--- tests/capture_tb.sv
`timescale 1ns/1ps

module capture_tb;

    localparam int NUM_READS      = 2000;
    localparam int RESET_CYCLES   = 16;
    localparam int QUIET_CYCLES   = 20;      // Zero inputs before the status sweep
    localparam int TIMEOUT_CYCLES = 40000;   // 2000 reads at up to 15 cycles each, plus margin

    logic                  clk;
    logic                  rst;
    capture_pkg::in_word_t chan_data [capture_pkg::N_CHAN];
    logic                  io_sel;
    logic                  io_rd_en;
    capture_pkg::addr_t    io_addr;
    capture_pkg::word_t    io_rd_data;
    logic                  io_rd_ack;

    logic                  gen_en;           // Random channel data on

    // Reference model
    capture_pkg::word_t    model_mem     [capture_pkg::N_CHAN][capture_pkg::DEPTH];
    logic                  model_written [capture_pkg::N_CHAN][capture_pkg::DEPTH];
    capture_pkg::entry_t   model_ptr     [capture_pkg::N_CHAN];
    capture_pkg::chan_t    model_chan;
    capture_pkg::entry_t   model_entry;
    capture_pkg::word_t    exp_word;
    capture_pkg::word_t    last_data;
    logic                  ack_pending;
    int                    ack_due;
    int                    cycle;
    int                    accepts;
    int                    acks;

    tb_clock clk_i (
        .clk (clk)
    );

    capture_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .chan_data  (chan_data),
        .io_sel     (io_sel),
        .io_rd_en   (io_rd_en),
        .io_addr    (io_addr),
        .io_rd_data (io_rd_data),
        .io_rd_ack  (io_rd_ack)
    );

    //////////////////////////////////////////////////
    // Checks

    task automatic fail_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_word(input string name, input capture_pkg::word_t exp,
                              input capture_pkg::word_t act);
        if (act !== exp) begin
            $display("ERR %0t %s expected %08h actual %08h", $time, name, exp, act);
            fail_run();
        end
    endtask

    task automatic check_ack(input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %0t io_rd_ack expected %0b actual %0b", $time, exp, act);
            fail_run();
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus

    function automatic capture_pkg::in_word_t random_word();
        int unsigned           pick;
        capture_pkg::in_word_t w;
        pick = $urandom_range(15, 0);
        w = '0;
        if (pick == 8) begin
            w[capture_pkg::IN_W-1:capture_pkg::WORD_W] = 4'($urandom_range(15, 1));  // Upper only
        end else if (pick > 8) begin
            w = {4'($urandom), capture_pkg::word_t'($urandom)};
        end
        return w;
    endfunction

    always @(posedge clk) begin
        for (int c = 0; c < capture_pkg::N_CHAN; c++) begin
            if (rst || !gen_en) begin
                chan_data[c] <= '0;
            end else begin
                chan_data[c] <= random_word();
            end
        end
    end

    // One request cycle, optional ignored requests while pending, then wait for ack
    task automatic issue_read(input capture_pkg::addr_t addr, input int extra);
        @(posedge clk);
        io_sel   <= 1'b1;
        io_rd_en <= 1'b1;
        io_addr  <= addr;
        repeat (extra) begin
            @(posedge clk);
            io_addr <= capture_pkg::addr_t'($urandom);
        end
        @(posedge clk);
        io_sel   <= 1'b0;
        io_rd_en <= 1'b0;
        do begin
            @(posedge clk);
        end while (io_rd_ack !== 1'b1);
    endtask

    task automatic random_read();
        capture_pkg::chan_t  ch;
        capture_pkg::entry_t ent;
        capture_pkg::addr_t  addr;
        logic                status;
        int                  gap;
        ch     = capture_pkg::chan_t'($urandom_range(capture_pkg::N_CHAN - 1, 0));
        ent    = capture_pkg::entry_t'($urandom_range(capture_pkg::DEPTH - 1, 0));
        status = ($urandom_range(3, 0) == 0);
        if (!status && !model_written[ch][ent]) begin
            status = 1'b1;    // Never read an entry that holds no data yet
        end
        addr = '0;
        addr[capture_pkg::STATUS_BIT] = status;
        addr[capture_pkg::CHAN_LSB +: capture_pkg::CHAN_W] = ch;
        addr[capture_pkg::ENTRY_W-1:0] = ent;
        gap = $urandom_range(6, 0);
        repeat (gap) begin
            @(posedge clk);
            io_sel <= 1'($urandom_range(1, 0));    // Select without read enable
        end
        issue_read(addr, int'($urandom_range(2, 0)));
    endtask

    //////////////////////////////////////////////////
    // Model and per-cycle checks

    always @(posedge clk) begin
        if (rst) begin
            for (int c = 0; c < capture_pkg::N_CHAN; c++) begin
                model_ptr[c] = '0;
            end
            ack_pending = 1'b0;
            ack_due     = 0;
            cycle       = 0;
            accepts     = 0;
            acks        = 0;
            last_data   = '0;
        end else begin
            cycle++;
            if (cycle >= TIMEOUT_CYCLES) begin
                $display("Run timed out after %0d cycles", cycle);
                fail_run();
            end
            check_ack(ack_pending && (cycle == ack_due), io_rd_ack);
            if (io_rd_ack) begin
                acks++;
                ack_pending = 1'b0;
                check_word("io_rd_data", exp_word, io_rd_data);
                last_data = exp_word;
            end else begin
                check_word("io_rd_data", last_data, io_rd_data);    // Held between acks
            end
            for (int c = 0; c < capture_pkg::N_CHAN; c++) begin
                if (chan_data[c] != '0) begin
                    model_mem[c][model_ptr[c]]     = chan_data[c][capture_pkg::WORD_W-1:0];
                    model_written[c][model_ptr[c]] = 1'b1;
                    model_ptr[c]                   = model_ptr[c] + 1'b1;
                end
            end
            // Expected value includes the word captured at this edge
            if (io_sel && io_rd_en && !ack_pending) begin
                model_chan  = io_addr[capture_pkg::CHAN_LSB +: capture_pkg::CHAN_W];
                model_entry = io_addr[capture_pkg::ENTRY_W-1:0];
                if (io_addr[capture_pkg::STATUS_BIT]) begin
                    exp_word = capture_pkg::word_t'(model_ptr[model_chan]);
                end else begin
                    exp_word = model_mem[model_chan][model_entry];
                end
                ack_pending = 1'b1;
                ack_due     = cycle + 4;
                accepts++;
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence

    initial begin
        rst      = 1'b1;
        gen_en   = 1'b0;
        io_sel   = 1'b0;
        io_rd_en = 1'b0;
        io_addr  = '0;
        for (int c = 0; c < capture_pkg::N_CHAN; c++) begin
            chan_data[c] = '0;
            for (int e = 0; e < capture_pkg::DEPTH; e++) begin
                model_written[c][e] = 1'b0;
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        void'($urandom(32'h6046bd65));
        repeat (QUIET_CYCLES) @(posedge clk);

        // Status of every channel right after reset
        for (int c = 0; c < capture_pkg::N_CHAN; c++) begin
            issue_read(capture_pkg::addr_t'((1 << capture_pkg::STATUS_BIT) |
                                            (c << capture_pkg::CHAN_LSB)), 0);
        end

        gen_en <= 1'b1;
        for (int i = 0; i < NUM_READS; i++) begin
            random_read();
        end
        repeat (8) @(posedge clk);    // Catch stray acks

        if (acks == accepts && acks == NUM_READS + capture_pkg::N_CHAN) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("Saw %0d acks for %0d accepted reads", acks, accepts);
            fail_run();
        end
    end

endmodule

//--- list.f
logic/capture_pkg.sv
logic/readback_if.sv
logic/write_pointer.sv
logic/capture_memory.sv
logic/capture_bank.sv
logic/readback_fsm.sv
logic/capture_top.sv
tests/tb_clock.sv
tests/capture_assertions.sv
tests/capture_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
    --top-module capture_tb -f list.f -o capture_sim

result=$(./obj_dir/capture_sim 2>&1 || true)
echo "$result"

if grep -qF '*** PASSED ***' <<< "$result"; then
    exit 0
fi
exit 1
